/* rtl/vdu_cfg.svh */
`ifndef VDU_CFG_SVH
`define VDU_CFG_SVH

// horizontal timing in pixel clocks, 525 per line
`define VDU_H_ACTIVE 480
`define VDU_H_FRONT 2
`define VDU_H_SYNC 41
`define VDU_H_BACK 2

// vertical timing in lines, 286 per frame
`define VDU_V_ACTIVE 272
`define VDU_V_FRONT 2
`define VDU_V_SYNC 10
`define VDU_V_BACK 2

// bitmap geometry
`define VDU_BMP_SIZE 64 // square bitmap, one bit per pixel
`define VDU_SCALE_SHIFT 2 // magnify by four

// top left corner of the magnified window
`define VDU_WIN_X 112
`define VDU_WIN_Y 8

// rgb565 colours as {r, g, b}
`define VDU_INK {5'd30, 6'd48, 5'd0} // yellow
`define VDU_PAPER {5'd2, 6'd6, 5'd14} // blue

`endif

/* rtl/vdu_pkg.sv */
`default_nettype none

package vdu_pkg;

	typedef logic [9:0] coord_t; // screen x or y
	typedef logic [8:0] vram_addr_t; // display memory byte address
	typedef logic [7:0] vram_data_t;

	typedef struct packed {
		logic hsync; // active low
		logic vsync; // active low
		logic de;
	} sync_t;

	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} rgb565_t;

	typedef struct packed {
		logic we;
		vram_addr_t addr;
		vram_data_t data;
	} host_wr_t;

	// memory port request, 19 bits
	typedef struct packed {
		logic en;
		logic we;
		vram_addr_t addr;
		vram_data_t data;
	} vram_req_t;

endpackage

`default_nettype wire

/* rtl/lcd_timing.sv */
`default_nettype none
`timescale 1ns/1ps
`include "vdu_cfg.svh"

module lcd_timing (
	input wire logic clk_pix,
	input wire logic i_arst_n,
	output vdu_pkg::coord_t o_sx,
	output vdu_pkg::coord_t o_sy,
	output vdu_pkg::sync_t o_sync,
	output logic o_frame
);

	localparam int H_TOTAL = `VDU_H_ACTIVE + `VDU_H_FRONT + `VDU_H_SYNC + `VDU_H_BACK;
	localparam int V_TOTAL = `VDU_V_ACTIVE + `VDU_V_FRONT + `VDU_V_SYNC + `VDU_V_BACK;
	localparam int HS_START = `VDU_H_ACTIVE + `VDU_H_FRONT;
	localparam int HS_END = HS_START + `VDU_H_SYNC;
	localparam int VS_START = `VDU_V_ACTIVE + `VDU_V_FRONT;
	localparam int VS_END = VS_START + `VDU_V_SYNC;

	vdu_pkg::coord_t h_next;
	vdu_pkg::coord_t v_next;
	vdu_pkg::sync_t sync_next;

	// advance to the next pixel position
	always_comb begin
		h_next = o_sx + 1'b1;
		v_next = o_sy;
		if (o_sx == vdu_pkg::coord_t'(H_TOTAL - 1)) begin
			h_next = '0;
			if (o_sy == vdu_pkg::coord_t'(V_TOTAL - 1)) begin
				v_next = '0; // wrap to a new frame
			end else begin
				v_next = o_sy + 1'b1;
			end
		end
	end

	always_comb begin
		sync_next.hsync = !(h_next >= HS_START && h_next < HS_END);
		sync_next.vsync = !(v_next >= VS_START && v_next < VS_END);
		sync_next.de = (h_next < `VDU_H_ACTIVE) && (v_next < `VDU_V_ACTIVE);
	end

	always_ff @(posedge clk_pix or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_sx <= vdu_pkg::coord_t'(H_TOTAL - 1); // last pixel of back porch
			o_sy <= vdu_pkg::coord_t'(V_TOTAL - 1);
			o_sync <= '{hsync: 1'b1, vsync: 1'b1, de: 1'b0};
			o_frame <= 1'b0;
		end else begin
			o_sx <= h_next;
			o_sy <= v_next;
			o_sync <= sync_next;
			o_frame <= (h_next == '0) && (v_next == '0); // first pixel of frame
		end
	end

endmodule

`default_nettype wire

/* rtl/display_ram.sv */
`default_nettype none
`timescale 1ns/1ps

module display_ram (
	input wire logic clk_pix,
	input wire vdu_pkg::vram_req_t i_req,
	output vdu_pkg::vram_data_t o_rdata
);

	localparam int DEPTH = 1 << $bits(vdu_pkg::vram_addr_t);

	vdu_pkg::vram_data_t mem [DEPTH];

	// blank bitmap at power up
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	// read first, byte out one cycle later
	always_ff @(posedge clk_pix) begin
		if (i_req.en) begin
			if (i_req.we) begin
				mem[i_req.addr] <= i_req.data;
			end
			o_rdata <= mem[i_req.addr];
		end
	end

endmodule

`default_nettype wire

/* rtl/vram_arbiter.sv */
`default_nettype none
`timescale 1ns/1ps

module vram_arbiter (
	input wire logic clk_pix,
	input wire logic i_arst_n,
	input wire vdu_pkg::host_wr_t i_host,
	output logic o_host_pending,
	input wire logic i_vid_rd_en,
	input wire vdu_pkg::vram_addr_t i_vid_addr,
	output vdu_pkg::vram_data_t o_vid_data,
	output vdu_pkg::vram_req_t o_req,
	input wire vdu_pkg::vram_data_t i_rdata
);

	logic pend_q; // a host write waits in the buffer
	logic commit;
	vdu_pkg::vram_addr_t wr_addr_q;
	vdu_pkg::vram_data_t wr_data_q;

	// video always wins the port
	assign commit = pend_q && !i_vid_rd_en;

	always_comb begin
		o_req = '0;
		if (i_vid_rd_en) begin
			o_req.en = 1'b1;
			o_req.addr = i_vid_addr;
		end else if (pend_q) begin
			o_req.en = 1'b1;
			o_req.we = 1'b1;
			o_req.addr = wr_addr_q;
			o_req.data = wr_data_q;
		end
	end

	always_ff @(posedge clk_pix or negedge i_arst_n) begin
		if (!i_arst_n) begin
			pend_q <= 1'b0;
		end else if (i_host.we) begin
			pend_q <= 1'b1; // new strobe replaces any parked write
		end else if (commit) begin
			pend_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_pix) begin
		if (i_host.we) begin
			wr_addr_q <= i_host.addr;
			wr_data_q <= i_host.data;
		end
	end

	assign o_host_pending = pend_q;
	assign o_vid_data = i_rdata; // only video ever reads

endmodule

`default_nettype wire

/* rtl/bitmap_fetch.sv */
`default_nettype none
`timescale 1ns/1ps
`include "vdu_cfg.svh"

module bitmap_fetch (
	input wire logic clk_pix,
	input wire logic i_arst_n,
	input wire logic i_en,
	input wire vdu_pkg::coord_t i_sx,
	input wire vdu_pkg::coord_t i_sy,
	output logic o_rd_en,
	output vdu_pkg::vram_addr_t o_rd_addr,
	input wire vdu_pkg::vram_data_t i_rd_data,
	output logic o_drawing
);

	localparam int BMP_BITS = $clog2(`VDU_BMP_SIZE); // bits of bitmap x or y
	localparam int WIN_SPAN = `VDU_BMP_SIZE << `VDU_SCALE_SHIFT;

	vdu_pkg::coord_t dx;
	vdu_pkg::coord_t dy;
	logic [BMP_BITS-1:0] bmp_x;
	logic [BMP_BITS-1:0] bmp_y;
	logic in_win;
	logic in_win_q;
	logic [2:0] bit_idx_q; // pixel within the byte

	assign dx = i_sx - vdu_pkg::coord_t'(`VDU_WIN_X);
	assign dy = i_sy - vdu_pkg::coord_t'(`VDU_WIN_Y);

	// undo the magnification
	assign bmp_x = dx[`VDU_SCALE_SHIFT +: BMP_BITS];
	assign bmp_y = dy[`VDU_SCALE_SHIFT +: BMP_BITS];

	assign in_win = i_en
		&& (i_sx >= `VDU_WIN_X) && (i_sx < `VDU_WIN_X + WIN_SPAN)
		&& (i_sy >= `VDU_WIN_Y) && (i_sy < `VDU_WIN_Y + WIN_SPAN);

	// row major, eight pixels per byte
	assign o_rd_en = in_win;
	assign o_rd_addr = {bmp_y, bmp_x[BMP_BITS-1:3]};

	always_ff @(posedge clk_pix or negedge i_arst_n) begin
		if (!i_arst_n) begin
			in_win_q <= 1'b0;
			o_drawing <= 1'b0;
		end else begin
			in_win_q <= in_win;
			o_drawing <= in_win_q && i_rd_data[3'd7 - bit_idx_q]; // msb is leftmost
		end
	end

	always_ff @(posedge clk_pix) begin
		bit_idx_q <= bmp_x[2:0];
	end

endmodule

`default_nettype wire

/* rtl/pixel_output.sv */
`default_nettype none
`timescale 1ns/1ps
`include "vdu_cfg.svh"

module pixel_output (
	input wire logic clk_pix,
	input wire logic i_arst_n,
	input wire logic i_en,
	input wire vdu_pkg::sync_t i_sync,
	input wire logic i_drawing,
	output vdu_pkg::sync_t o_sync,
	output vdu_pkg::rgb565_t o_rgb
);

	localparam vdu_pkg::sync_t SYNC_IDLE = '{hsync: 1'b1, vsync: 1'b1, de: 1'b0};

	vdu_pkg::sync_t sync_d1;
	vdu_pkg::sync_t sync_d2;
	logic en_d1;
	logic en_d2;
	vdu_pkg::rgb565_t paint;

	// drawing flag lines up with the second stage
	always_comb begin
		if (sync_d2.de && en_d2) begin
			paint = i_drawing ? vdu_pkg::rgb565_t'(`VDU_INK) : vdu_pkg::rgb565_t'(`VDU_PAPER);
		end else begin
			paint = '0; // black in blanking or when off
		end
	end

	always_ff @(posedge clk_pix or negedge i_arst_n) begin
		if (!i_arst_n) begin
			sync_d1 <= SYNC_IDLE;
			sync_d2 <= SYNC_IDLE;
			o_sync <= SYNC_IDLE;
			en_d1 <= 1'b0;
			en_d2 <= 1'b0;
			o_rgb <= '0;
		end else begin
			sync_d1 <= i_sync;
			sync_d2 <= sync_d1;
			o_sync <= sync_d2;
			en_d1 <= i_en;
			en_d2 <= en_d1;
			o_rgb <= paint;
		end
	end

endmodule

`default_nettype wire

/* rtl/vdu_lcd_top.sv */
`default_nettype none
`timescale 1ns/1ps

module vdu_lcd_top (
	input wire logic clk_pix,
	input wire logic i_arst_n,
	input wire logic i_en,
	input wire vdu_pkg::host_wr_t i_host,
	output logic o_host_pending,
	output logic o_hsync,
	output logic o_vsync,
	output logic o_de,
	output vdu_pkg::rgb565_t o_rgb,
	output logic o_frame
);

	vdu_pkg::coord_t sx;
	vdu_pkg::coord_t sy;
	vdu_pkg::sync_t tim_sync; // aligned with sx, sy
	vdu_pkg::sync_t pix_sync; // aligned with o_rgb
	logic vid_rd_en;
	vdu_pkg::vram_addr_t vid_addr;
	vdu_pkg::vram_data_t vid_data;
	vdu_pkg::vram_req_t ram_req;
	vdu_pkg::vram_data_t ram_rdata;
	logic drawing;

	lcd_timing u_timing (
		.clk_pix(clk_pix),
		.i_arst_n(i_arst_n),
		.o_sx(sx),
		.o_sy(sy),
		.o_sync(tim_sync),
		.o_frame(o_frame)
	);

	bitmap_fetch u_fetch (
		.clk_pix(clk_pix),
		.i_arst_n(i_arst_n),
		.i_en(i_en),
		.i_sx(sx),
		.i_sy(sy),
		.o_rd_en(vid_rd_en),
		.o_rd_addr(vid_addr),
		.i_rd_data(vid_data),
		.o_drawing(drawing)
	);

	vram_arbiter u_arbiter (
		.clk_pix(clk_pix),
		.i_arst_n(i_arst_n),
		.i_host(i_host),
		.o_host_pending(o_host_pending),
		.i_vid_rd_en(vid_rd_en),
		.i_vid_addr(vid_addr),
		.o_vid_data(vid_data),
		.o_req(ram_req),
		.i_rdata(ram_rdata)
	);

	display_ram u_ram (
		.clk_pix(clk_pix),
		.i_req(ram_req),
		.o_rdata(ram_rdata)
	);

	pixel_output u_output (
		.clk_pix(clk_pix),
		.i_arst_n(i_arst_n),
		.i_en(i_en),
		.i_sync(tim_sync),
		.i_drawing(drawing),
		.o_sync(pix_sync),
		.o_rgb(o_rgb)
	);

	assign o_hsync = pix_sync.hsync;
	assign o_vsync = pix_sync.vsync;
	assign o_de = pix_sync.de;

endmodule

`default_nettype wire

/* verif/tb_vdu_lcd_top.sv */
`default_nettype none
`timescale 1ns/1ps
`include "vdu_cfg.svh"

module tb_vdu_lcd_top;

	localparam int RESET_CYCLES = 8;
	localparam int LINE_CYCLES = 525;
	localparam int FRAME_CYCLES = LINE_CYCLES * 286;
	localparam int TIMEOUT_CYCLES = 4 * FRAME_CYCLES + RESET_CYCLES + LINE_CYCLES;
	localparam int COMMIT_LIMIT = 482; // worst wait for a parked write
	localparam int WIN_SPAN = `VDU_BMP_SIZE << `VDU_SCALE_SHIFT;
	localparam int ROW_BYTES = `VDU_BMP_SIZE / 8;
	localparam int PIPE_LAT = 3; // coordinate to panel output
	localparam int STROBE_X = 200; // panel x of a strobe inside the window
	localparam int VIDEO_ROW = 200; // first line used for writes against reads
	// reads run to the window end, the commit cycle still shows pending
	localparam int PARK_HOLD = `VDU_WIN_X + WIN_SPAN - STROBE_X - PIPE_LAT;
	localparam vdu_pkg::rgb565_t INK = `VDU_INK;
	localparam vdu_pkg::rgb565_t PAPER = `VDU_PAPER;

	// write phase flag, address and byte
	typedef struct packed {
		logic during_video;
		vdu_pkg::vram_addr_t addr;
		vdu_pkg::vram_data_t data;
	} wr_entry_t;

	localparam int N_WR = 10;
	wr_entry_t wr_table [N_WR] = '{
		{1'b0, 9'd0, 8'h80}, // top left corner pixel
		{1'b0, 9'd7, 8'h01}, // top right corner pixel
		{1'b0, 9'd504, 8'h80}, // bottom left
		{1'b0, 9'd511, 8'h01}, // bottom right
		{1'b0, 9'd260, 8'hff},
		{1'b0, 9'd261, 8'h00},
		{1'b0, 9'd100, 8'h5a},
		{1'b1, 9'd1, 8'hc3}, // rows 0..3 are already drawn when these go in
		{1'b1, 9'd16, 8'hff},
		{1'b1, 9'd31, 8'h3c}
	};

	logic clk_pix;
	logic i_arst_n;
	logic i_en;
	vdu_pkg::host_wr_t host;
	logic o_host_pending;
	logic o_hsync;
	logic o_vsync;
	logic o_de;
	vdu_pkg::rgb565_t o_rgb;
	logic o_frame;

	vdu_pkg::vram_data_t shadow [512];
	logic [15:0] lfsr = 16'd18061;
	int err_count = 0;
	int cycles = 0;
	int frames_seen = 0;
	int px = 0;
	int py = 0;
	int line_len = 0;
	int hs_low = 0;
	int vs_lines = 0;
	logic line_seen = 1'b0;
	logic frame_en = 1'b1;
	logic de_q = 1'b0;
	logic hs_q = 1'b1;

	vdu_lcd_top u_dut (
		.clk_pix(clk_pix),
		.i_arst_n(i_arst_n),
		.i_en(i_en),
		.i_host(host),
		.o_host_pending(o_host_pending),
		.o_hsync(o_hsync),
		.o_vsync(o_vsync),
		.o_de(o_de),
		.o_rgb(o_rgb),
		.o_frame(o_frame)
	);

	initial begin
		clk_pix = 1'b0;
		forever #50 clk_pix = ~clk_pix; // 100 ns period
	end

	task automatic fail_run();
		err_count++;
		$display("Result: FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_rgb(input string name, input vdu_pkg::rgb565_t got,
			input vdu_pkg::rgb565_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s = %h, expected %h (x %0d, y %0d)",
				$time, name, got, exp, px, py);
			fail_run();
		end
	endtask

	task automatic check_coord(input string name, input vdu_pkg::coord_t got,
			input vdu_pkg::coord_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
			fail_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp);
			fail_run();
		end
	endtask

	// galois lfsr with taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 16'hb400;
		end
		return n;
	endfunction

	task automatic random_byte(output vdu_pkg::vram_data_t b);
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr); // one step per bit
			b = {b[6:0], lfsr[0]};
		end
	endtask

	// colour of one active pixel from the shadow bitmap
	function automatic vdu_pkg::rgb565_t expected_colour(input int x, input int y, input logic en);
		int bx;
		int by;
		vdu_pkg::vram_data_t b;
		if (!en) begin
			return '0;
		end
		if (x < `VDU_WIN_X || x >= `VDU_WIN_X + WIN_SPAN
				|| y < `VDU_WIN_Y || y >= `VDU_WIN_Y + WIN_SPAN) begin
			return PAPER;
		end
		bx = (x - `VDU_WIN_X) >> `VDU_SCALE_SHIFT;
		by = (y - `VDU_WIN_Y) >> `VDU_SCALE_SHIFT;
		b = shadow[by * ROW_BYTES + bx / 8];
		return b[7 - (bx % 8)] ? INK : PAPER; // msb is the leftmost pixel
	endfunction

	// starts and ends on a falling edge
	task automatic host_write(input vdu_pkg::vram_addr_t addr, input vdu_pkg::vram_data_t data,
			input int hold);
		int waited;
		host.we = 1'b1;
		host.addr = addr;
		host.data = data;
		shadow[addr] = data;
		@(negedge clk_pix);
		host.we = 1'b0;
		waited = 0;
		while (waited < hold) begin
			check_bit("o_host_pending while parked", o_host_pending, 1'b1);
			@(negedge clk_pix);
			waited++;
		end
		while (o_host_pending && waited < COMMIT_LIMIT) begin
			@(negedge clk_pix);
			waited++;
		end
		check_bit("o_host_pending after commit bound", o_host_pending, 1'b0);
	endtask

	task automatic wait_frames(input int n);
		while (frames_seen < n) begin
			@(negedge clk_pix);
		end
	endtask

	task automatic wait_vsync();
		do begin
			@(negedge clk_pix);
		end while (o_vsync);
	endtask

	// panel pixel STROBE_X of a late active line, fetched from inside the window
	task automatic wait_window_pixel();
		do begin
			do begin
				@(negedge clk_pix);
			end while (o_de);
			do begin
				@(negedge clk_pix);
			end while (!o_de);
		end while (py < VIDEO_ROW);
		repeat (STROBE_X) @(negedge clk_pix);
	endtask

	task automatic apply_table(input logic during_video);
		for (int i = 0; i < N_WR; i++) begin
			if (wr_table[i].during_video == during_video) begin
				if (during_video) begin
					wait_window_pixel();
					host_write(wr_table[i].addr, wr_table[i].data, PARK_HOLD);
				end else begin
					host_write(wr_table[i].addr, wr_table[i].data, 1);
				end
			end
		end
	endtask

	initial begin
		forever begin
			@(posedge clk_pix);
			cycles++;
			if (cycles > TIMEOUT_CYCLES) begin
				$display("timeout, the test did not finish within %0d cycles", TIMEOUT_CYCLES);
				fail_run();
			end
		end
	end

	// frame scoreboard
	always @(negedge clk_pix) begin
		if (i_arst_n) begin
			if (o_frame) begin
				if (frames_seen > 0) begin
					check_coord("o_de lines per frame", vdu_pkg::coord_t'(py), 10'd272);
					check_coord("o_vsync low lines", vdu_pkg::coord_t'(vs_lines), 10'd10);
				end
				frames_seen++;
				py = 0;
				vs_lines = 0;
				frame_en = i_en; // i_en only moves inside vsync
			end
			if (frames_seen > 0) begin
				if (o_de) begin
					check_rgb("o_rgb", o_rgb, expected_colour(px, py, frame_en));
					px++;
				end else begin
					check_rgb("o_rgb in blanking", o_rgb, '0);
					if (de_q) begin
						check_coord("o_de pixels per line", vdu_pkg::coord_t'(px), 10'd480);
						px = 0;
						py++;
					end
				end
				if (!o_hsync && hs_q) begin
					if (line_seen) begin
						check_coord("o_hsync line length", vdu_pkg::coord_t'(line_len), 10'd525);
					end
					line_seen = 1'b1;
					line_len = 1;
					if (!o_vsync) begin
						vs_lines++;
					end
				end else begin
					line_len++;
				end
				if (!o_hsync) begin
					hs_low++;
				end else begin
					if (!hs_q) begin
						check_coord("o_hsync low cycles", vdu_pkg::coord_t'(hs_low), 10'd41);
					end
					hs_low = 0;
				end
			end
			de_q = o_de;
			hs_q = o_hsync;
		end
	end

	initial begin
		vdu_pkg::vram_data_t b;
		i_arst_n = 1'b0;
		i_en = 1'b1;
		host = '0;
		for (int a = 0; a < 512; a++) begin
			shadow[a] = '0;
		end
		repeat (RESET_CYCLES) @(negedge clk_pix);
		check_bit("o_de in reset", o_de, 1'b0);
		check_bit("o_hsync in reset", o_hsync, 1'b1);
		check_bit("o_vsync in reset", o_vsync, 1'b1);
		check_bit("o_host_pending in reset", o_host_pending, 1'b0);
		check_rgb("o_rgb in reset", o_rgb, '0);
		i_arst_n = 1'b1;

		wait_frames(1); // blank bitmap shows all paper
		wait_vsync();
		for (int a = 0; a < 512; a++) begin
			random_byte(b);
			host_write(vdu_pkg::vram_addr_t'(a), b, 1);
		end
		apply_table(1'b0);

		wait_frames(2); // full picture while late writes contend with video reads
		apply_table(1'b1);

		wait_frames(3); // picture holds the late writes
		wait_vsync();
		i_en = 1'b0;

		wait_frames(5); // black frame checked at the next frame pulse
		@(negedge clk_pix);
		if (err_count == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			$display("Result: FAILED");
			$fatal(1, "errors were counted");
		end
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+rtl
rtl/vdu_pkg.sv
rtl/lcd_timing.sv
rtl/display_ram.sv
rtl/vram_arbiter.sv
rtl/bitmap_fetch.sv
rtl/pixel_output.sv
rtl/vdu_lcd_top.sv
verif/tb_vdu_lcd_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_vdu_lcd_top
LOG ?= sim.log
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary -Wno-fatal

SOURCES := $(shell grep -v '^+' src.f) rtl/vdu_cfg.svh
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): src.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f src.f --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
